//--- common/debugCoreIf.sv
`timescale 1ns/100ps
`default_nettype none

interface debugCoreIf;
	import mcuPkg::*;
	import debugPkg::*;

	logic stop;
	logic step;
	logic coreReset;
	logic readReq;
	debugOp_t readOp;
	dataWord_t readAddr;
	dataWord_t readData;
	logic readDone;
	logic stopped;

	modport host(output stop, step, coreReset, readReq, readOp, readAddr,
		input readData, readDone, stopped);

	modport target(input stop, step, coreReset, readReq, readOp, readAddr,
		output readData, readDone, stopped);

endinterface

`default_nettype wire

//--- common/debugPkg.sv
`default_nettype none

package debugPkg;

	typedef enum logic [2:0] {
		regMode = 3'd0,
		regOp = 3'd1,
		regAl = 3'd2,
		regAh = 3'd3,
		regDl = 3'd4,
		regDh = 3'd5
	} debugReg_t;

	// Bit positions in the mode byte
	localparam int modeStop = 0;
	localparam int modeReq = 1;
	localparam int modeDebug = 2;
	localparam int modeReset = 3;

	// Lives in bits 7 to 5 of the op byte
	typedef enum logic [2:0] {
		opRdMem = 3'd0,
		opRdPc = 3'd1,
		opRdInstruction = 3'd2,
		opRdCc = 3'd3
	} debugOp_t;

	localparam int opIncBit = 0;

endpackage

`default_nettype wire

//--- common/mcuPkg.sv
`default_nettype none

package mcuPkg;

	typedef logic [15:0] dataWord_t;

	typedef enum logic [3:0] {
		opNop = 4'h0,
		opLdi = 4'h1,
		opAddi = 4'h2,
		opSubi = 4'h3,
		opOut = 4'h4,
		opJmp = 4'h5,
		opJz = 4'h6
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [11:0] imm; // Sign extended to 16 bits by the core
	} immInstr_t;

	typedef struct packed {
		opcode_t opcode;
		logic [1:0] reserved;
		logic [9:0] target;
	} jmpInstr_t;

	// Same word seen in two ways, the opcode tells which one applies
	typedef union packed {
		immInstr_t imm;
		jmpInstr_t jmp;
	} instrWord_t;

	typedef struct packed {
		logic [4:0] reserved;
		logic carry;
		logic negative;
		logic zero;
	} condCodes_t;

	localparam int bootAddrBits = 4;
	localparam int bootLength = 1 << bootAddrBits;

	localparam instrWord_t bootProgram [bootLength] = '{
		0: 16'h1000, // LDI 0
		1: 16'h2001, // ADDI 1
		2: 16'h4000, // OUT
		3: 16'h6000, // JZ 0
		4: 16'h3000, // SUBI 0
		5: 16'h5001, // JMP 1
		default: 16'h0000
	};

endpackage

`default_nettype wire

//--- debug/debugPort.sv
`timescale 1ns/100ps
`default_nettype none

module debugPort (
	input wire logic clkX1,
	input wire logic rstN,
	input wire debugPkg::debugReg_t debugAddr,
	input wire logic [7:0] debugDin,
	input wire logic debugWrN,
	output logic [7:0] debugDout,
	debugCoreIf.host dbg
);
	import debugPkg::*;

	typedef enum logic [1:0] {seqIdle, seqRead, seqStepStart, seqStepRun} seqState_t;

	logic [1:0] wrSync;
	logic wrPrev;
	logic wrEdge;
	logic modeWrite;
	logic startReq;
	logic readFinish;
	logic reqDone;
	logic incAddr;
	logic [7:0] modeReg;
	logic [7:0] opReg;
	logic [7:0] alReg;
	logic [7:0] ahReg;
	logic [7:0] dlReg;
	logic [7:0] dhReg;
	seqState_t seq;

	// Host strobe is asynchronous to clkX1
	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			wrSync <= 2'b11;
			wrPrev <= 1'b1;
		end else begin
			wrSync <= {wrSync[0], debugWrN};
			wrPrev <= wrSync[1];
		end
	end

	assign wrEdge = wrSync[1] & ~wrPrev; // Rising edge of the synchronized strobe
	assign modeWrite = wrEdge && debugAddr == regMode;
	assign startReq = modeWrite && debugDin[modeReq];
	assign readFinish = seq == seqRead && dbg.readDone;
	assign reqDone = readFinish || (seq == seqStepRun && dbg.stopped);
	assign incAddr = readFinish && dbg.readOp == opRdMem && opReg[opIncBit];

	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			modeReg <= '0;
			opReg <= '0;
			alReg <= '0;
			ahReg <= '0;
			dlReg <= '0;
			dhReg <= '0;
		end else begin
			if (reqDone)
				modeReg[modeReq] <= 1'b0;
			if (incAddr)
				{ahReg, alReg} <= {ahReg, alReg} + 16'd1;
			if (readFinish) begin
				dlReg <= dbg.readData[7:0];
				dhReg <= dbg.readData[15:8];
			end
			// A host write wins over a completion in the same cycle
			if (wrEdge) begin
				case (debugAddr)
					regMode: begin
						modeReg <= debugDin;
						modeReg[modeReset] <= 1'b0; // Reset is a one-shot command
					end
					regOp: opReg <= debugDin;
					regAl: alReg <= debugDin;
					regAh: ahReg <= debugDin;
					default: ;
				endcase
			end
		end
	end

	// Turns the request bit into a single pulse and follows the action to its end
	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			seq <= seqIdle;
			dbg.step <= 1'b0;
			dbg.readReq <= 1'b0;
			dbg.coreReset <= 1'b0;
		end else begin
			dbg.step <= startReq && !debugDin[modeDebug];
			dbg.readReq <= startReq && debugDin[modeDebug];
			dbg.coreReset <= modeWrite && debugDin[modeReset];
			if (startReq) begin
				seq <= debugDin[modeDebug] ? seqRead : seqStepStart;
			end else begin
				case (seq)
					seqStepStart: if (!dbg.stopped) seq <= seqStepRun; // Core has left stop
					seqRead, seqStepRun: if (reqDone) seq <= seqIdle;
					default: ;
				endcase
			end
		end
	end

	assign dbg.stop = modeReg[modeStop];
	assign dbg.readOp = debugOp_t'(opReg[7:5]);
	assign dbg.readAddr = {ahReg, alReg};

	always_comb begin
		case (debugAddr)
			regMode: debugDout = modeReg;
			regOp: debugDout = opReg;
			regAl: debugDout = alReg;
			regAh: debugDout = ahReg;
			regDl: debugDout = dlReg;
			regDh: debugDout = dhReg;
			default: debugDout = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

//--- project.f
common/mcuPkg.sv
common/debugPkg.sv
common/debugCoreIf.sv
debug/debugPort.sv
verilog/cpuCore.sv
verilog/programRom.sv
verilog/mcu.sv
tests/clockGen.sv
tests/debugPort_chk.sv
tests/mcuTests.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module mcuTests -f project.f -o simMcu

# The log decides the result, so a failing run must not stop the script here
./obj_dir/simMcu > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- tests/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter int periodNs = 40,
	parameter int resetCycles = 16
) (
	output logic clkX1,
	output logic rstN
);

	initial begin
		clkX1 = 1'b0;
		forever #(periodNs / 2) clkX1 = ~clkX1;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clkX1);
		@(negedge clkX1);
		rstN = 1'b1; // Released half a cycle away from the sampling edge
	end

endmodule

`default_nettype wire

//--- tests/debugPort_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mcuChk (
	input wire logic clkX1,
	input wire logic rstN,
	input wire logic stoppedN,
	input wire logic fetchN,
	input wire logic decodeN,
	input wire logic executeN,
	input wire logic commitN,
	input wire logic debugStop
);

	logic [4:0] strobesN;

	assign strobesN = {stoppedN, fetchN, decodeN, executeN, commitN};

	oneStrobeLow: assert property (@(posedge clkX1) disable iff (!rstN) $onehot(~strobesN))
		else $error("Phase strobes are not one-hot low");

	// A running instruction walks through the phases in a fixed order
	fetchThenDecode: assert property (@(posedge clkX1) disable iff (!rstN)
		!fetchN |=> !decodeN)
		else $error("Decode did not follow fetch");
	decodeThenExecute: assert property (@(posedge clkX1) disable iff (!rstN)
		!decodeN |=> !executeN)
		else $error("Execute did not follow decode");
	executeThenCommit: assert property (@(posedge clkX1) disable iff (!rstN)
		!executeN |=> !commitN)
		else $error("Commit did not follow execute");
	commitThenNext: assert property (@(posedge clkX1) disable iff (!rstN)
		!commitN |=> (!fetchN || !stoppedN))
		else $error("Commit was followed by neither fetch nor stop");

	stopFlag: assert property (@(posedge clkX1) disable iff (!rstN) !stoppedN |-> debugStop)
		else $error("debugStop is low while the core is stopped");

endmodule

bind mcu mcuChk mcuChkInst (
	.clkX1(clkX1),
	.rstN(rstN),
	.stoppedN(stoppedN),
	.fetchN(fetchN),
	.decodeN(decodeN),
	.executeN(executeN),
	.commitN(commitN),
	.debugStop(debugStop)
);

`default_nettype wire

//--- tests/mcuTests.sv
`timescale 1ns/100ps
`default_nettype none

module mcuTests;
	import mcuPkg::*;
	import debugPkg::*;

	localparam int romAddrBits = 10;
	localparam int reqTimeout = 200;
	localparam int stopTimeout = 50;
	localparam int outTimeout = 1000;
	localparam int watchdogCycles = 20000;
	localparam int randomSeed = 91377;

	localparam logic [7:0] stopBit = 8'(1 << modeStop);
	localparam logic [7:0] reqBit = 8'(1 << modeReq);
	localparam logic [7:0] debugBit = 8'(1 << modeDebug);
	localparam logic [7:0] resetBit = 8'(1 << modeReset);

	logic clkX1;
	logic rstN;
	logic stoppedN;
	logic fetchN;
	logic decodeN;
	logic executeN;
	logic commitN;
	dataWord_t addrBus;
	dataWord_t dataBus;
	logic [7:0] led;
	logic [2:0] debugAddr;
	logic [7:0] debugDin;
	logic [7:0] debugDout;
	logic debugWrN;
	logic debugStop;

	int checkCount = 0;
	int errorCount = 0;
	int timeoutCount = 0;
	int outSeen = 0;
	logic outPending = 1'b0;

	// Reference model state, advanced once per observed commit
	logic [romAddrBits-1:0] modelPc = '0;
	dataWord_t modelAcc = '0;
	condCodes_t modelCc = '0;
	logic [7:0] modelLed = '0;
	instrWord_t modelInstr = '0;

	clockGen #(.periodNs(40), .resetCycles(16)) clockGenInst (.clkX1(clkX1), .rstN(rstN));

	mcu #(.romAddrBits(romAddrBits)) DUT (
		.clkX1(clkX1),
		.rstN(rstN),
		.stoppedN(stoppedN),
		.fetchN(fetchN),
		.decodeN(decodeN),
		.executeN(executeN),
		.commitN(commitN),
		.addrBus(addrBus),
		.dataBus(dataBus),
		.led(led),
		.debugAddr(debugAddr),
		.debugDin(debugDin),
		.debugDout(debugDout),
		.debugWrN(debugWrN),
		.debugStop(debugStop)
	);

	task automatic checkWord(input string name, input dataWord_t got, input dataWord_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic checkInstr(input string name, input instrWord_t got, input instrWord_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic checkCc(input string name, input condCodes_t got, input condCodes_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic finishRun();
		$display("Checks: %0d, value errors: %0d, timeouts: %0d",
			checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	// ROM contents as the ISA sees them, NOP past the boot table
	function automatic instrWord_t fetchWord(input dataWord_t addr);
		logic [romAddrBits-1:0] a;
		a = addr[romAddrBits-1:0];
		if (int'(a) < bootLength)
			return bootProgram[a[bootAddrBits-1:0]];
		return '0;
	endfunction

	function automatic void modelStep();
		instrWord_t w;
		dataWord_t imm;
		logic [16:0] r;
		logic taken;
		w = fetchWord(dataWord_t'(modelPc));
		imm = {{4{w.imm.imm[11]}}, w.imm.imm};
		taken = 1'b0;
		case (w.imm.opcode)
			opLdi: begin
				modelAcc = imm;
				modelCc.zero = imm == '0;
				modelCc.negative = imm[15];
			end
			opAddi, opSubi: begin
				if (w.imm.opcode == opAddi)
					r = {1'b0, modelAcc} + {1'b0, imm};
				else
					r = {1'b0, modelAcc} - {1'b0, imm}; // Carry holds the borrow
				modelAcc = r[15:0];
				modelCc.zero = r[15:0] == '0;
				modelCc.negative = r[15];
				modelCc.carry = r[16];
			end
			opOut: modelLed = modelAcc[7:0];
			opJmp: taken = 1'b1;
			opJz: taken = modelCc.zero;
			default: ;
		endcase
		modelInstr = w;
		modelPc = taken ? romAddrBits'(w.jmp.target) : modelPc + romAddrBits'(1);
	endfunction

	// A core reset leaves led alone
	function automatic void modelReset();
		modelPc = '0;
		modelAcc = '0;
		modelCc = '0;
	endfunction

	// Follows every commit of the DUT and checks led one cycle after each OUT
	always @(negedge clkX1) begin
		if (outPending) begin
			checkByte("led", led, modelLed);
			outSeen = outSeen + 1;
			outPending = 1'b0;
		end
		// In decode the buses show the fetched address and its ROM word
		if (rstN === 1'b1 && decodeN === 1'b0) begin
			checkWord("addrBus", addrBus, dataWord_t'(modelPc));
			checkInstr("dataBus", instrWord_t'(dataBus), fetchWord(dataWord_t'(modelPc)));
		end
		if (rstN === 1'b1 && commitN === 1'b0) begin
			modelStep();
			outPending = modelInstr.imm.opcode == opOut;
		end
	end

	function automatic logic [7:0] opByte(input debugOp_t op, input logic inc);
		return {op, 4'b0000, inc};
	endfunction

	// Address and data stay put until the synchronized strobe has done its work
	task automatic debugWrite(input debugReg_t addr, input logic [7:0] data);
		@(negedge clkX1);
		debugAddr = addr;
		debugDin = data;
		debugWrN = 1'b0;
		repeat (2) @(negedge clkX1);
		debugWrN = 1'b1;
		repeat (4) @(negedge clkX1);
	endtask

	task automatic debugRead(input debugReg_t addr, output logic [7:0] data);
		@(negedge clkX1);
		debugAddr = addr;
		@(negedge clkX1);
		data = debugDout;
	endtask

	task automatic waitReqClear();
		logic [7:0] mode;
		int cycles;
		cycles = 0;
		mode = reqBit;
		while (mode[modeReq] !== 1'b0 && cycles < reqTimeout) begin
			debugRead(regMode, mode);
			cycles += 2;
		end
		if (mode[modeReq] !== 1'b0) begin
			timeoutCount++;
			$display("Timeout at %0t: the debug request bit never cleared", $time);
		end
	endtask

	task automatic waitForReset();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < 100) begin
			@(negedge clkX1);
			cycles++;
		end
		if (rstN !== 1'b1) begin
			timeoutCount++;
			$display("Timeout at %0t: reset was never released", $time);
		end
	endtask

	task automatic waitOutCount(input int target, input string what);
		int cycles;
		cycles = 0;
		while (outSeen < target && cycles < outTimeout) begin
			@(negedge clkX1);
			cycles++;
		end
		if (outSeen < target) begin
			timeoutCount++;
			$display("Timeout at %0t: no OUT commit number %0d while %s", $time, target, what);
		end
	endtask

	task automatic waitStopState(input logic wantStopped);
		int cycles;
		cycles = 0;
		while (debugStop !== wantStopped && cycles < stopTimeout) begin
			@(negedge clkX1);
			cycles++;
		end
		if (debugStop !== wantStopped) begin
			timeoutCount++;
			$display("Timeout at %0t: debugStop never became %0b", $time, wantStopped);
		end
	endtask

	task automatic requestRead(output dataWord_t word);
		logic [7:0] lo;
		logic [7:0] hi;
		debugWrite(regMode, stopBit | reqBit | debugBit);
		waitReqClear();
		debugRead(regDl, lo);
		debugRead(regDh, hi);
		word = {hi, lo};
	endtask

	task automatic readCore(input debugOp_t op, output dataWord_t word);
		debugWrite(regOp, opByte(op, 1'b0));
		requestRead(word);
	endtask

	task automatic stepOnce();
		debugWrite(regMode, stopBit | reqBit);
		waitReqClear();
	endtask

	task automatic resetCore();
		debugWrite(regMode, stopBit | resetBit);
		modelReset();
	endtask

	task automatic checkCoreState();
		dataWord_t word;
		readCore(opRdPc, word);
		checkWord("pc", word, dataWord_t'(modelPc));
		readCore(opRdInstruction, word);
		checkInstr("instruction", instrWord_t'(word), modelInstr);
		readCore(opRdCc, word);
		checkCc("condition codes", condCodes_t'(word[7:0]), modelCc);
		checkByte("condition code high byte", word[15:8], 8'h00);
	endtask

	task automatic runFreeAndStop();
		waitOutCount(outSeen + 4, "running after reset");
		debugWrite(regMode, stopBit);
		waitStopState(1'b1);
		repeat (12) begin
			@(negedge clkX1);
			checkByte("phase strobes", {3'b000, stoppedN, fetchN, decodeN, executeN, commitN},
				8'h0F);
		end
	endtask

	// One start inside the boot table, one anywhere, one that carries from AL into AH
	task automatic readMemoryBurst();
		dataWord_t starts [3];
		dataWord_t word;
		logic [7:0] lo;
		logic [7:0] hi;
		starts[0] = dataWord_t'($urandom % 14);
		starts[1] = dataWord_t'($urandom % ((1 << romAddrBits) - 2));
		starts[2] = {8'($urandom % 3), 8'hFE};
		debugWrite(regOp, opByte(opRdMem, 1'b1));
		foreach (starts[i]) begin
			debugWrite(regAl, starts[i][7:0]);
			debugWrite(regAh, starts[i][15:8]);
			for (int k = 0; k < 3; k++) begin
				requestRead(word);
				checkInstr("memory word", instrWord_t'(word), fetchWord(starts[i] + dataWord_t'(k)));
			end
			debugRead(regAl, lo);
			debugRead(regAh, hi);
			checkWord("address register", {hi, lo}, starts[i] + 16'd3);
		end
	endtask

	task automatic stepFromReset();
		resetCore();
		repeat (7) begin
			stepOnce();
			checkCoreState();
		end
	endtask

	task automatic resetWhileStopped();
		dataWord_t word;
		resetCore();
		readCore(opRdPc, word);
		checkWord("pc after core reset", word, 16'h0000);
		readCore(opRdCc, word);
		checkCc("condition codes after core reset", condCodes_t'(word[7:0]), '0);
		stepOnce();
		checkCoreState();
	endtask

	task automatic resumeRunning();
		debugWrite(regMode, 8'h00);
		waitStopState(1'b0);
		waitOutCount(outSeen + 3, "running after resume");
	endtask

	initial begin
		debugAddr = 3'd0;
		debugDin = 8'h00;
		debugWrN = 1'b1;
		void'($urandom(randomSeed));
		waitForReset();
		runFreeAndStop();
		readMemoryBurst();
		stepFromReset();
		resetWhileStopped();
		resumeRunning();
		finishRun();
	end

	initial begin
		for (int i = 0; i < watchdogCycles; i++)
			@(posedge clkX1);
		timeoutCount++;
		$display("Watchdog expired at %0t before the tests finished", $time);
		finishRun();
	end

endmodule

`default_nettype wire

//--- verilog/cpuCore.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCore #(
	parameter int romAddrBits = 10
) (
	input wire logic clkX1,
	input wire logic rstN,
	input wire mcuPkg::instrWord_t romData,
	output logic [romAddrBits-1:0] romAddr,
	output logic [7:0] led,
	output logic stoppedN,
	output logic fetchN,
	output logic decodeN,
	output logic executeN,
	output logic commitN,
	debugCoreIf.target dbg
);
	import mcuPkg::*;
	import debugPkg::*;

	typedef enum logic [2:0] {sFetch, sDecode, sExecute, sCommit, sStopped} phase_t;

	phase_t phase;
	logic [romAddrBits-1:0] pc;
	instrWord_t ir;
	dataWord_t acc;
	condCodes_t cc;
	dataWord_t immExt;
	logic [16:0] aluSum;
	logic [16:0] aluDiff;
	logic branchTaken;
	logic readPending;

	assign immExt = {{4{ir.imm.imm[11]}}, ir.imm.imm};
	assign aluSum = {1'b0, acc} + {1'b0, immExt};
	assign aluDiff = {1'b0, acc} - {1'b0, immExt}; // Bit 16 is the borrow
	assign branchTaken = ir.jmp.opcode == opJmp || (ir.jmp.opcode == opJz && cc.zero);

	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			phase <= sFetch;
		end else if (dbg.coreReset && phase != sStopped) begin
			phase <= sFetch; // Restart a running core at a clean boundary
		end else begin
			case (phase)
				sFetch: phase <= sDecode;
				sDecode: phase <= sExecute;
				sExecute: phase <= sCommit;
				sCommit: phase <= dbg.stop ? sStopped : sFetch;
				sStopped: if (dbg.step || !dbg.stop) phase <= sFetch;
				default: phase <= sFetch;
			endcase
		end
	end

	always_ff @(posedge clkX1) begin
		if (phase == sDecode)
			ir <= romData;
	end

	always_ff @(posedge clkX1) begin
		if (!rstN || dbg.coreReset) begin
			pc <= '0;
			acc <= '0;
			cc <= '0;
		end else if (phase == sExecute) begin
			case (ir.imm.opcode)
				opLdi: begin
					acc <= immExt;
					cc.zero <= immExt == '0;
					cc.negative <= immExt[15];
				end
				opAddi: begin
					acc <= aluSum[15:0];
					cc.zero <= aluSum[15:0] == '0;
					cc.negative <= aluSum[15];
					cc.carry <= aluSum[16];
				end
				opSubi: begin
					acc <= aluDiff[15:0];
					cc.zero <= aluDiff[15:0] == '0;
					cc.negative <= aluDiff[15];
					cc.carry <= aluDiff[16];
				end
				default: ;
			endcase
		end else if (phase == sCommit) begin
			pc <= branchTaken ? romAddrBits'(ir.jmp.target) : pc + 1'b1;
		end
	end

	always_ff @(posedge clkX1) begin
		if (!rstN)
			led <= '0;
		else if (phase == sCommit && ir.imm.opcode == opOut)
			led <= acc[7:0];
	end

	// Debug reads answer two cycles after the request, the ROM needs one of them
	always_ff @(posedge clkX1) begin
		if (!rstN) begin
			readPending <= 1'b0;
			dbg.readDone <= 1'b0;
		end else begin
			readPending <= dbg.readReq && phase == sStopped;
			dbg.readDone <= readPending;
		end
	end

	always_ff @(posedge clkX1) begin
		if (readPending) begin
			case (dbg.readOp)
				opRdMem: dbg.readData <= romData;
				opRdPc: dbg.readData <= dataWord_t'(pc);
				opRdInstruction: dbg.readData <= ir;
				opRdCc: dbg.readData <= dataWord_t'(cc);
				default: dbg.readData <= '0;
			endcase
		end
	end

	assign romAddr = (phase == sStopped) ? romAddrBits'(dbg.readAddr) : pc;

	assign dbg.stopped = phase == sStopped;
	assign stoppedN = phase != sStopped;
	assign fetchN = phase != sFetch;
	assign decodeN = phase != sDecode;
	assign executeN = phase != sExecute;
	assign commitN = phase != sCommit;

endmodule

`default_nettype wire

//--- verilog/mcu.sv
`timescale 1ns/100ps
`default_nettype none

module mcu #(
	parameter int romAddrBits = 10
) (
	input wire logic clkX1,
	input wire logic rstN,
	output logic stoppedN,
	output logic fetchN,
	output logic decodeN,
	output logic executeN,
	output logic commitN,
	output mcuPkg::dataWord_t addrBus,
	output mcuPkg::dataWord_t dataBus,
	output logic [7:0] led,
	input wire logic [2:0] debugAddr,
	input wire logic [7:0] debugDin,
	output logic [7:0] debugDout,
	input wire logic debugWrN,
	output logic debugStop
);
	import mcuPkg::*;
	import debugPkg::*;

	logic [romAddrBits-1:0] romAddr;
	instrWord_t romData;

	debugCoreIf dbg ();

	debugPort debugPortInst (
		.clkX1(clkX1),
		.rstN(rstN),
		.debugAddr(debugReg_t'(debugAddr)),
		.debugDin(debugDin),
		.debugWrN(debugWrN),
		.debugDout(debugDout),
		.dbg(dbg)
	);

	cpuCore #(.romAddrBits(romAddrBits)) cpuCoreInst (
		.clkX1(clkX1),
		.rstN(rstN),
		.romData(romData),
		.romAddr(romAddr),
		.led(led),
		.stoppedN(stoppedN),
		.fetchN(fetchN),
		.decodeN(decodeN),
		.executeN(executeN),
		.commitN(commitN),
		.dbg(dbg)
	);

	programRom #(.romAddrBits(romAddrBits)) programRomInst (
		.clkX1(clkX1),
		.romAddr(romAddr),
		.romData(romData)
	);

	assign addrBus = dataWord_t'(romAddr); // ROM address bus seen from outside
	assign dataBus = romData;
	assign debugStop = ~stoppedN;

endmodule

`default_nettype wire

//--- verilog/programRom.sv
`timescale 1ns/100ps
`default_nettype none

module programRom #(
	parameter int romAddrBits = 10
) (
	input wire logic clkX1,
	input wire logic [romAddrBits-1:0] romAddr,
	output mcuPkg::instrWord_t romData
);
	import mcuPkg::*;

	logic inTable;

	assign inTable = int'(romAddr) < bootLength;

	// Words past the boot table decode as NOP
	always_ff @(posedge clkX1) begin
		if (inTable)
			romData <= bootProgram[bootAddrBits'(romAddr)];
		else
			romData <= '0;
	end

endmodule

`default_nettype wire
